// ==== rtl/lock_pkg.sv ====
package lock_pkg;

    // lock FSM states, also reported in STATUS[1:0]
    typedef enum logic [1:0] {
        ENTRY   = 2'd0,
        OPEN    = 2'd1,
        LOCKOUT = 2'd2
    } lock_state_t;

    // three BCD digits per code
    localparam int CODE_W      = 12;
    localparam int CODE_DIGITS = 3;

    // display patterns
    localparam logic [CODE_W-1:0] DISP_BLANK = 12'hFFF;
    localparam logic [CODE_W-1:0] DISP_OPEN  = 12'hBCC; // "ASS" on the segment decoder
    localparam logic [CODE_W-1:0] DISP_LOCK  = 12'h000;

    localparam logic [CODE_W-1:0] RESET_CODE = 12'h246;

    // AXI4-Lite register offsets
    localparam logic [31:0] ADDR_CODE   = 32'h0;
    localparam logic [31:0] ADDR_STATUS = 32'h4;
    localparam logic [31:0] ADDR_CTRL   = 32'h8;

endpackage

// ==== rtl/key_bus_if.sv ====
`timescale 1ns/1ps

// decoded key events, one valid pulse per accepted press
interface key_bus_if;

    logic       valid;
    logic [3:0] digit;       // BCD value, meaningful for digit keys only
    logic       enter;
    logic       clear_entry;
    logic       clear_all;

    modport source (
        output valid, digit, enter, clear_entry, clear_all
    );

    // no back-pressure, sink takes every event
    modport sink (
        input valid, digit, enter, clear_entry, clear_all
    );

endinterface

// ==== rtl/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] onehot,
    key_bus_if.source   keys
);

    logic [15:0] onehot_prev;
    logic        fresh;      // idle before, exactly one key now
    logic        hit;        // the key is mapped
    logic [3:0]  dig;
    logic        is_enter;
    logic        is_clr_entry;
    logic        is_clr_all;

    assign fresh = (onehot_prev == '0) && $onehot(onehot);

    // key map
    always_comb begin
        hit          = 1'b1;
        dig          = 4'd0;
        is_enter     = 1'b0;
        is_clr_entry = 1'b0;
        is_clr_all   = 1'b0;
        case (onehot)
            16'h0001: is_enter     = 1'b1;
            16'h0100: is_clr_all   = 1'b1;
            16'h1000: is_clr_entry = 1'b1;
            16'h0008: dig = 4'd0;
            16'h0080: dig = 4'd1;
            16'h0040: dig = 4'd2;
            16'h0020: dig = 4'd3;
            16'h0800: dig = 4'd4;
            16'h0400: dig = 4'd5;
            16'h0200: dig = 4'd6;
            16'h8000: dig = 4'd7;
            16'h4000: dig = 4'd8;
            16'h2000: dig = 4'd9;
            default:  hit = 1'b0; // keys 1, 2, 4 and multi-key input
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            onehot_prev <= '0;
            keys.valid  <= 1'b0;
        end else begin
            onehot_prev <= onehot;
            keys.valid  <= fresh && hit;
        end
    end

    always_ff @(posedge clk) begin
        keys.digit       <= dig;
        keys.enter       <= is_enter;
        keys.clear_entry <= is_clr_entry;
        keys.clear_all   <= is_clr_all;
    end

endmodule

// ==== rtl/digit_shift_reg.sv ====
`timescale 1ns/1ps

module digit_shift_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       shift_en,
    input  logic [3:0]                 shift_digit,
    input  logic                       entry_clear,
    output logic [lock_pkg::CODE_W-1:0] digits,
    output logic [1:0]                 count
);

    import lock_pkg::*;

    logic full;

    assign full = (count == 2'(CODE_DIGITS));

    // newest digit in the low nibble, older ones move up
    always_ff @(posedge clk) begin
        if (rst || entry_clear) begin
            digits <= '1;
            count  <= 2'd0;
        end else if (shift_en && !full) begin
            digits <= {digits[CODE_W-5:0], shift_digit};
            count  <= count + 2'd1;
        end
    end

endmodule

// ==== rtl/alarm_timer.sv ====
`timescale 1ns/1ps

module alarm_timer #(
    parameter int ALARM_CYCLES = 25_000_000
) (
    input  logic clk,
    input  logic rst,
    input  logic alarm_start,
    output logic buzzer
);

    localparam int CNT_W = $clog2(ALARM_CYCLES + 1);

    logic [CNT_W-1:0] remaining;

    // restart wins over counting down, so a repeat failure extends it
    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
        end else if (alarm_start) begin
            remaining <= CNT_W'(ALARM_CYCLES);
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign buzzer = (remaining != '0); // high for exactly ALARM_CYCLES

endmodule

// ==== rtl/lock_fsm.sv ====
`timescale 1ns/1ps

module lock_fsm #(
    parameter int MAX_TRIES = 6
) (
    input  logic                        clk,
    input  logic                        rst,
    key_bus_if.sink                     keys,
    input  logic [lock_pkg::CODE_W-1:0] digits,
    input  logic [1:0]                  count,
    input  logic [lock_pkg::CODE_W-1:0] code,
    input  logic                        cmd_clear_all,
    output logic                        shift_en,
    output logic [3:0]                  shift_digit,
    output logic                        entry_clear,
    output logic                        alarm_start,
    output lock_pkg::lock_state_t       state,
    output logic [3:0]                  tries,
    output logic [lock_pkg::CODE_W-1:0] display,
    output logic                        unlocked,
    output logic                        locked_out
);

    import lock_pkg::*;

    lock_state_t state_next;
    logic [3:0]  tries_next;
    logic        clear_all_req;
    logic        entry_full;

    // clear-all from the keypad or from the register block
    assign clear_all_req = cmd_clear_all || (keys.valid && keys.clear_all);
    assign entry_full    = (count == 2'(CODE_DIGITS));
    assign shift_digit   = keys.digit;

    always_comb begin
        state_next  = state;
        tries_next  = tries;
        shift_en    = 1'b0;
        entry_clear = 1'b0;
        alarm_start = 1'b0;

        if (clear_all_req) begin
            state_next  = ENTRY;
            tries_next  = 4'd0;
            entry_clear = 1'b1;
        end else if (keys.valid) begin
            case (state)
                ENTRY: begin
                    if (keys.clear_entry) begin
                        entry_clear = 1'b1;
                    end else if (keys.enter) begin
                        if (entry_full) begin // short entries are ignored
                            entry_clear = 1'b1;
                            if (digits == code) begin
                                state_next = OPEN;
                            end else begin
                                tries_next  = tries + 4'd1;
                                alarm_start = 1'b1;
                                if (tries_next == 4'(MAX_TRIES))
                                    state_next = LOCKOUT;
                            end
                        end
                    end else begin
                        shift_en = 1'b1; // digit key
                    end
                end
                OPEN: begin
                    if (keys.clear_entry) begin
                        state_next  = ENTRY;
                        entry_clear = 1'b1;
                    end
                end
                LOCKOUT: ; // only clear-all gets out
                default: state_next = ENTRY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENTRY;
            tries <= 4'd0;
        end else begin
            state <= state_next;
            tries <= tries_next;
        end
    end

    always_comb begin
        case (state)
            OPEN:    display = DISP_OPEN;
            LOCKOUT: display = DISP_LOCK;
            default: display = digits; // blank until digits come in
        endcase
    end

    assign unlocked   = (state == OPEN);
    assign locked_out = (state == LOCKOUT);

endmodule

// ==== rtl/lock_axil_regs.sv ====
`timescale 1ns/1ps

module lock_axil_regs (
    input  logic                        clk,
    input  logic                        rst,
    // write address and data
    input  logic [31:0]                 awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    // write response
    output logic                        bvalid,
    output logic [1:0]                  bresp,
    input  logic                        bready,
    // read
    input  logic [31:0]                 araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic                        rvalid,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    input  logic                        rready,
    // lock side
    input  lock_pkg::lock_state_t       state,
    input  logic [3:0]                  tries,
    input  logic [1:0]                  count,
    output logic [lock_pkg::CODE_W-1:0] code,
    output logic                        cmd_clear_all
);

    import lock_pkg::*;

    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] status;
    logic [31:0] rd_word;

    // address and data taken together, nothing new while a response waits
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign rd_fire = arvalid && !rvalid;
    assign arready = rd_fire;

    assign bresp = 2'b00; // always OKAY
    assign rresp = 2'b00;

    always_comb begin
        status      = '0;
        status[1:0] = state;
        status[7:4] = tries;
        status[9:8] = count;
    end

    always_comb begin
        case (araddr)
            ADDR_CODE:   rd_word = 32'(code);
            ADDR_STATUS: rd_word = status;
            default:     rd_word = '0; // CTRL is write-only
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            code          <= RESET_CODE;
            cmd_clear_all <= 1'b0;
            bvalid        <= 1'b0;
        end else begin
            cmd_clear_all <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (awaddr == ADDR_CODE) begin
                    if (wstrb[0])
                        code[7:0] <= wdata[7:0];
                    if (wstrb[1])
                        code[11:8] <= wdata[11:8];
                end else if (awaddr == ADDR_CTRL) begin
                    cmd_clear_all <= wstrb[0] && wdata[0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // held stable until rready
    always_ff @(posedge clk) begin
        if (rd_fire)
            rdata <= rd_word;
    end

endmodule

// ==== rtl/code_lock_top.sv ====
`timescale 1ns/1ps

module code_lock_top #(
    parameter int ALARM_CYCLES = 25_000_000,
    parameter int MAX_TRIES    = 6
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [15:0]                 onehot,
    // AXI4-Lite slave
    input  logic [31:0]                 awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic                        bvalid,
    output logic [1:0]                  bresp,
    input  logic                        bready,
    input  logic [31:0]                 araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic                        rvalid,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    input  logic                        rready,
    // lock outputs
    output logic [lock_pkg::CODE_W-1:0] display,
    output logic                        unlocked,
    output logic                        locked_out,
    output logic                        buzzer,
    output logic [3:0]                  tries
);

    import lock_pkg::*;

    key_bus_if keys ();

    logic [CODE_W-1:0] digits;
    logic [1:0]        count;
    logic [CODE_W-1:0] code;
    logic              cmd_clear_all;
    logic              shift_en;
    logic [3:0]        shift_digit;
    logic              entry_clear;
    logic              alarm_start;
    lock_state_t       state;

    key_decoder key_decoder_inst (
        .clk    (clk),
        .rst    (rst),
        .onehot (onehot),
        .keys   (keys.source)
    );

    digit_shift_reg digit_shift_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .shift_en    (shift_en),
        .shift_digit (shift_digit),
        .entry_clear (entry_clear),
        .digits      (digits),
        .count       (count)
    );

    alarm_timer #(
        .ALARM_CYCLES (ALARM_CYCLES)
    ) alarm_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .alarm_start (alarm_start),
        .buzzer      (buzzer)
    );

    lock_fsm #(
        .MAX_TRIES (MAX_TRIES)
    ) lock_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .keys          (keys.sink),
        .digits        (digits),
        .count         (count),
        .code          (code),
        .cmd_clear_all (cmd_clear_all),
        .shift_en      (shift_en),
        .shift_digit   (shift_digit),
        .entry_clear   (entry_clear),
        .alarm_start   (alarm_start),
        .state         (state),
        .tries         (tries),
        .display       (display),
        .unlocked      (unlocked),
        .locked_out    (locked_out)
    );

    lock_axil_regs lock_axil_regs_inst (
        .clk           (clk),
        .rst           (rst),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bvalid        (bvalid),
        .bresp         (bresp),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rready        (rready),
        .state         (state),
        .tries         (tries),
        .count         (count),
        .code          (code),
        .cmd_clear_all (cmd_clear_all)
    );

endmodule

// ==== tb/code_lock_checker.sv ====
`timescale 1ns/1ps

module code_lock_checker #(
    parameter int ALARM_CYCLES = 20
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        buzzer,
    input logic                        unlocked,
    input logic                        locked_out,
    input logic [lock_pkg::CODE_W-1:0] display,
    input logic                        bvalid,
    input logic                        bready,
    input logic                        rvalid,
    input logic                        rready,
    input logic [31:0]                 rdata
);

    import lock_pkg::*;

    int high_run;     // consecutive cycles with buzzer high
    int failures = 0;

    always_ff @(posedge clk) begin
        if (rst || !buzzer) begin
            high_run <= 0;
        end else begin
            high_run <= high_run + 1;
        end
    end

    buzzer_length: assert property (@(posedge clk) disable iff (rst)
        $fell(buzzer) |-> high_run >= ALARM_CYCLES)
    else begin
        $error("buzzer high for only %0d cycles", high_run);
        failures++;
    end

    open_xor_locked: assert property (@(posedge clk) disable iff (rst)
        !(unlocked && locked_out))
    else begin
        $error("unlocked and locked_out both high");
        failures++;
    end

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        failures++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        failures++;
    end

    lock_display: assert property (@(posedge clk) disable iff (rst)
        locked_out |-> display == DISP_LOCK)
    else begin
        $error("locked out but display is %h", display);
        failures++;
    end

endmodule

bind code_lock_top code_lock_checker #(
    .ALARM_CYCLES (ALARM_CYCLES)
) code_lock_checker_inst (
    .clk        (clk),
    .rst        (rst),
    .buzzer     (buzzer),
    .unlocked   (unlocked),
    .locked_out (locked_out),
    .display    (display),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata)
);

// ==== tb/code_lock_tb.sv ====
`timescale 1ns/1ps

module code_lock_tb;

    import lock_pkg::*;

    localparam int ALARM_CYCLES   = 20;
    localparam int MAX_TRIES      = 3;
    localparam int TIMEOUT_CYCLES = 6000; // tests need under 3000 cycles

    // digits 0 to 9 on the keypad bits
    localparam int DIGIT_BIT [10] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};
    localparam logic [15:0] KEY_ENTER       = 16'h0001;
    localparam logic [15:0] KEY_CLEAR_ALL   = 16'h0100;
    localparam logic [15:0] KEY_CLEAR_ENTRY = 16'h1000;

    logic        clk;
    logic        rst;
    logic [15:0] onehot;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [11:0] display;
    logic        unlocked, locked_out, buzzer;
    logic [3:0]  tries;

    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    logic [31:0] lfsr   = 32'hb404_087d;
    logic [31:0] rd;
    logic [11:0] wrong;
    int          delay, width;

    code_lock_top #(
        .ALARM_CYCLES (ALARM_CYCLES),
        .MAX_TRIES    (MAX_TRIES)
    ) code_lock_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic take_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [15:0] digit_key(input logic [3:0] d);
        return 16'(1) << DIGIT_BIT[d];
    endfunction

    function automatic logic [31:0] status_word(input logic [1:0] st, input logic [3:0] tr,
                                                input logic [1:0] cnt);
        return {22'd0, cnt, tr, 2'b00, st};
    endfunction

    task automatic pick_wrong_code(input logic [11:0] avoid, output logic [11:0] code);
        logic [3:0] d;
        do begin
            for (int i = 0; i < 3; i++) begin
                d = '0;
                for (int b = 0; b < 4; b++)
                    d = {d[2:0], take_bit()};
                code = {code[7:0], 4'(d % 10)};
            end
        end while (code == avoid);
    endtask

    task automatic press_key(input logic [15:0] pattern);
        @(posedge clk);
        onehot <= pattern;
        repeat (3) @(posedge clk);
        onehot <= '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic enter_code(input logic [11:0] code);
        press_key(digit_key(code[11:8])); // first digit ends up in the top nibble
        press_key(digit_key(code[7:4]));
        press_key(digit_key(code[3:0]));
        press_key(KEY_ENTER);
    endtask

    // enter press that measures when buzzer rises and how long it stays high
    task automatic enter_and_time_buzzer(output int rise, output int high);
        @(posedge clk);
        onehot <= KEY_ENTER;
        @(posedge clk); // enter sampled on this edge
        rise = 0;
        high = 0;
        do begin
            @(negedge clk);
            rise++;
        end while (!buzzer && rise < 10);
        while (buzzer && high < 100) begin
            high++;
            @(negedge clk);
        end
        @(posedge clk);
        onehot <= '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check("write wready", 1, wready); // both readies pulse together
        @(posedge clk); // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        check("write response", 2'b00, bresp);
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        check("read response", 2'b00, rresp);
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
    endtask

    // three wrong codes in a row lock out on the last one
    task automatic fail_until_lockout();
        logic [11:0] bad;
        for (int i = 1; i <= MAX_TRIES; i++) begin
            pick_wrong_code(RESET_CODE, bad);
            enter_code(bad);
            check("lockout tries", i, tries);
            check("lockout flag", i == MAX_TRIES, locked_out);
        end
        check("lockout display", DISP_LOCK, display);
    endtask

    initial begin
        rst     = 1'b1;
        onehot  = '0;
        awaddr  = '0;
        wdata   = '0;
        wstrb   = 4'hf;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        check("reset display", DISP_BLANK, display);
        check("reset buzzer", 0, buzzer);
        check("reset unlocked", 0, unlocked);
        check("reset locked_out", 0, locked_out);
        check("reset bvalid", 0, bvalid);
        check("reset rvalid", 0, rvalid);
        check("reset tries", 0, tries);
        axi_read(ADDR_CODE, rd);
        check("reset code", 32'h246, rd);

        enter_code(12'h246);
        check("open unlocked", 1, unlocked);
        check("open display", DISP_OPEN, display);
        press_key(KEY_CLEAR_ENTRY);
        check("relock display", DISP_BLANK, display);
        check("relock unlocked", 0, unlocked);

        pick_wrong_code(RESET_CODE, wrong);
        press_key(digit_key(wrong[11:8]));
        press_key(digit_key(wrong[7:4]));
        press_key(digit_key(wrong[3:0]));
        enter_and_time_buzzer(delay, width);
        check("wrong tries", 1, tries);
        check("wrong display", DISP_BLANK, display);
        check("buzzer delay", 2, delay);
        check("buzzer width", ALARM_CYCLES, width);
        press_key(digit_key(4'd1));
        press_key(digit_key(4'd2));
        press_key(digit_key(4'd7) | digit_key(4'd8)); // room left for a third digit
        check("two keys", 12'hF12, display);
        press_key(digit_key(4'd3));
        press_key(digit_key(4'd5)); // fourth digit
        check("fourth digit", 12'h123, display);
        press_key(KEY_CLEAR_ENTRY);

        press_key(KEY_CLEAR_ALL);
        check("clear-all tries", 0, tries);
        fail_until_lockout();
        enter_code(12'h246);
        check("locked right code", 1, locked_out);
        check("locked unlocked", 0, unlocked);
        press_key(KEY_CLEAR_ALL);
        check("key clear locked_out", 0, locked_out);
        check("key clear tries", 0, tries);
        check("key clear display", DISP_BLANK, display);
        fail_until_lockout();
        axi_write(ADDR_CTRL, 32'h1);
        check("ctrl clear locked_out", 0, locked_out);
        check("ctrl clear tries", 0, tries);

        axi_write(ADDR_CODE, 32'h913);
        axi_read(ADDR_CODE, rd);
        check("new code", 32'h913, rd);
        axi_read(ADDR_STATUS, rd);
        check("status idle", status_word(ENTRY, 0, 0), rd);
        press_key(digit_key(4'd2));
        press_key(digit_key(4'd4));
        axi_read(ADDR_STATUS, rd);
        check("status two digits", status_word(ENTRY, 0, 2), rd);
        press_key(digit_key(4'd6));
        axi_read(ADDR_STATUS, rd);
        check("status three digits", status_word(ENTRY, 0, 3), rd);
        press_key(KEY_ENTER);
        check("old code unlocked", 0, unlocked);
        axi_read(ADDR_STATUS, rd);
        check("status old code", status_word(ENTRY, 1, 0), rd);
        enter_code(12'h913);
        check("new code unlocked", 1, unlocked);
        axi_read(ADDR_STATUS, rd);
        check("status open", status_word(OPEN, 1, 0), rd);

        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 code_lock_inst.code_lock_checker_inst.failures);
        if (errors == 0 && code_lock_inst.code_lock_checker_inst.failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/lock_pkg.sv
rtl/key_bus_if.sv
rtl/key_decoder.sv
rtl/digit_shift_reg.sv
rtl/alarm_timer.sv
rtl/lock_fsm.sv
rtl/lock_axil_regs.sv
rtl/code_lock_top.sv
tb/code_lock_checker.sv
tb/code_lock_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the code lock testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module code_lock_tb -f filelist.f \
    --Mdir obj_dir -o code_lock_sim

./obj_dir/code_lock_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
